/* flist.f */
+incdir+tb
source/cpuPkg.sv
source/accessTimer.sv
source/unifiedMemory.sv
source/registerFile.sv
source/alu.sv
source/mainController.sv
source/dataPath.sv
source/multiCycleCore.sv
tb/coreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
        --top-module coreTb -f flist.f -o coreSim

out=$(./obj_dir/coreSim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "PASS: all tests"; then
        echo "simulation passed"
        exit 0
fi

echo "simulation failed"
exit 1

/* tb/coreRefModel.svh */
// runs the program in refMem and returns 1 once it halts.
function automatic bit refRun(input int maxSteps);
        logic [31:0] x [32];
        logic [31:0] pc, w, a, b, nextPc, ea;
        logic [31:0] immI, immS, immB, immJ;
        logic [2:0] f3;
        logic [4:0] rd;
        bit done;
        for (int i = 0; i < 32; i++)
                x[i] = '0;
        pc = '0;
        done = 1'b0;
        for (int step = 0; step < maxSteps && !done; step++) begin
                w = refMem[pc[9:2]];
                a = x[w[19:15]];
                b = x[w[24:20]];
                f3 = w[14:12];
                rd = w[11:7];
                immI = {{20{w[31]}}, w[31:20]};
                immS = {{20{w[31]}}, w[31:25], w[11:7]};
                immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                nextPc = pc + 4;
                case (w[6:0])
                        OpRType: begin
                                case (f3)
                                        F3Add: x[rd] = w[30] ? a - b : a + b;
                                        F3Slt: x[rd] = {31'b0, $signed(a) < $signed(b)};
                                        F3Or: x[rd] = a | b;
                                        F3And: x[rd] = a & b;
                                        default: ;
                                endcase
                        end
                        OpIType: begin
                                ea = a + immI;
                                if (f3 == F3Lw) begin
                                        x[rd] = refMem[ea[9:2]];
                                end else if (f3 == F3Jalr) begin
                                        x[rd] = pc + 4;
                                        nextPc = ea;
                                end else begin
                                        x[rd] = ea;
                                end
                        end
                        OpSType: begin
                                ea = a + immS;
                                refMem[ea[9:2]] = b;
                        end
                        OpBType: begin
                                if ((f3 == F3Beq && a == b) || (f3 == F3Bne && a != b) ||
                                    (f3 == F3Blt && $signed(a) < $signed(b)))
                                        nextPc = pc + immB;
                        end
                        OpUType: x[rd] = {w[31:12], 12'b0};
                        OpJType: begin
                                x[rd] = pc + 4;
                                nextPc = pc + immJ;
                        end
                        OpHalt: done = 1'b1;
                        default: ;
                endcase
                x[0] = '0;
                pc = nextPc;
        end
        return done;
endfunction

/* tb/coreTb.sv */
module coreTb;
        timeunit 1ns;
        timeprecision 1ps;
        import cpuPkg::*;

        logic clk;
        logic rst;
        logic run;
        memReq_t extReq;
        logic extReady;
        logic [31:0] extRdata;
        logic halted;
        logic [31:0] image [MemWords];
        logic [31:0] refMem [MemWords];
        int progLen;
        integer seed;

        multiCycleCore uut (
                .clk(clk), .rst(rst), .run(run), .extReq(extReq),
                .extReady(extReady), .extRdata(extRdata), .halted(halted)
        );

        `include "coreRefModel.svh"

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        task automatic stopWithError(input string msg);
                $display("ERROR at %0t: %s", $time, msg);
                $display("FAIL: see errors above");
                $fatal(1);
        endtask

        task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
                if (act !== exp) begin
                        $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
                        $display("FAIL: see errors above");
                        $fatal(1);
                end
        endtask

        function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                             input int f3, input int rd);
                return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OpRType};
        endfunction

        function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                             input int rd);
                return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OpIType};
        endfunction

        function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
                return {imm[11:5], rs2[4:0], rs1[4:0], 3'd0, imm[4:0], OpSType};
        endfunction

        function automatic logic [31:0] encB(input int imm, input int f3, input int rs1,
                                             input int rs2);
                return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                        OpBType};
        endfunction

        function automatic logic [31:0] encJ(input int imm, input int rd);
                return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OpJType};
        endfunction

        // fill words differ for every address.
        task automatic clearImage();
                for (int a = 0; a < MemWords; a++)
                        image[a] = {8'hC3, ~a[7:0], a[7:0], a[7:0] ^ 8'h5A};
                progLen = 0;
        endtask

        task automatic emit(input logic [31:0] word);
                image[progLen] = word;
                progLen++;
        endtask

        task automatic resetDut();
                @(posedge clk);
                rst <= 1'b1;
                repeat (10) @(posedge clk);
                rst <= 1'b0;
        endtask

        task automatic extAccess(input bit wr, input logic [7:0] addr, input logic [31:0] data,
                                 output logic [31:0] q, output int lat);
                memReq_t r;
                int cycles;
                r.valid = 1'b1;
                r.write = wr;
                r.addr = addr;
                r.wdata = data;
                cycles = 0;
                @(posedge clk);
                extReq <= r;
                do begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > 50)
                                stopWithError("extReady never came on the external port");
                end while (!extReady);
                q = extRdata;
                lat = cycles - 1;
                @(posedge clk);
                extReq.valid <= 1'b0;
        endtask

        task automatic waitHalt();
                int cycles;
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > 20000)
                                stopWithError("core never reached the halted state");
                end while (!halted);
        endtask

        task automatic pulseRun();
                @(posedge clk);
                run <= 1'b1;
                @(posedge clk);
                run <= 1'b0;
        endtask

        task automatic readBack(input string tag);
                logic [31:0] q;
                int lat;
                for (int a = 0; a < MemWords; a++) begin
                        extAccess(1'b0, a[7:0], '0, q, lat);
                        checkEq($sformatf("%s extRdata mem[%0d]", tag, a), refMem[a], q);
                end
        endtask

        task automatic runProgram(input string tag);
                logic [31:0] q;
                int lat;
                for (int a = 0; a < MemWords; a++)
                        refMem[a] = image[a];
                if (!refRun(10000))
                        stopWithError("reference model never reached halt");
                resetDut();
                for (int a = 0; a < MemWords; a++)
                        extAccess(1'b1, a[7:0], image[a], q, lat);
                pulseRun();
                waitHalt();
                readBack(tag);
        endtask

        task automatic testExtPort();
                logic [31:0] d;
                logic [31:0] q;
                int lat;
                d = $random(seed);
                @(negedge clk);
                checkEq("halted", 32'd0, {31'b0, halted});
                checkEq("extReady", 32'd0, {31'b0, extReady});
                extAccess(1'b1, 8'hA7, d, q, lat);
                checkEq("write latency", MemLatency, lat);
                extAccess(1'b0, 8'hA7, '0, q, lat);
                checkEq("read latency", MemLatency, lat);
                checkEq("extRdata", d, q);
        endtask

        task automatic testAlu();
                clearImage();
                image[64] = $random(seed);
                image[65] = $random(seed);
                emit(encI(256, 0, F3Lw, 1));
                emit(encI(260, 0, F3Lw, 2));
                emit(encR(0, 2, 1, F3Add, 3));
                emit(encR(7'h20, 2, 1, F3Add, 4));
                emit(encR(0, 2, 1, F3And, 5));
                emit(encR(0, 2, 1, F3Or, 6));
                emit(encR(0, 2, 1, F3Slt, 7));
                emit(encR(0, 1, 2, F3Slt, 8));
                emit(encI($random(seed), 1, F3Add, 9));
                for (int r = 3; r <= 9; r++)
                        emit(encS(272 + 4 * (r - 3), r, 0));
                emit(32'd127);
                runProgram("alu");
        endtask

        task automatic testLoadStore();
                clearImage();
                image[80] = $random(seed);
                image[81] = $random(seed);
                emit(encI(320, 0, F3Add, 1));
                emit(encI(0, 1, F3Lw, 2));
                emit(encI(4, 1, F3Lw, 3));
                emit(encR(0, 3, 2, F3Add, 4));
                emit(encS(8, 4, 1));
                emit(encI(32, 1, F3Add, 1));
                // negative offsets from the moved base.
                emit(encS(-4, 2, 1));
                emit(encI(-24, 1, F3Lw, 5));
                emit(encS(4, 5, 1));
                emit(encS(-32, 3, 1));
                emit(32'd127);
                runProgram("load/store");
        endtask

        task automatic testBranches();
                int limit;
                limit = ($random(seed) & 7) + 2;
                clearImage();
                emit(encI(limit, 0, F3Add, 2));
                emit(encI(1, 1, F3Add, 1));
                emit(encB(-4, F3Bne, 1, 2));
                emit(encI(1, 3, F3Add, 3));
                emit(encB(-4, F3Blt, 3, 2));
                emit(encB(8, F3Beq, 1, 0));
                emit(encI(7, 0, F3Add, 4));
                emit(encI(-3, 0, F3Add, 5));
                emit(encB(8, F3Blt, 5, 0));
                emit(encI(99, 0, F3Add, 6));
                emit(encS(256, 1, 0));
                emit(encS(260, 3, 0));
                emit(encS(264, 4, 0));
                emit(encS(268, 6, 0));
                emit(32'd127);
                runProgram("branch");
        endtask

        task automatic testJumps();
                logic [31:0] lui;
                lui = {$random(seed)} & 32'hFFFFF000;
                clearImage();
                emit(lui | (32'd1 << 7) | OpUType);
                emit(encS(256, 1, 0));
                emit(encJ(12, 2));
                emit(encI(12'hBAD, 0, F3Add, 9));
                emit(encS(272, 9, 0));
                emit(encS(260, 2, 0));
                emit(encI(40, 0, F3Add, 5));
                emit(encI(0, 5, F3Jalr, 6));
                emit(encI(2, 0, F3Add, 9));
                emit(encS(272, 9, 0));
                emit(encS(264, 6, 0));
                emit(encI(12'h05A, 0, F3Add, 7));
                emit(encS(268, 7, 0));
                emit(32'd127);
                runProgram("jump");
                // run pulses after halt are ignored.
                repeat (3) pulseRun();
                repeat (20) begin
                        @(negedge clk);
                        checkEq("halted", 32'd1, {31'b0, halted});
                end
                readBack("after halt");
        endtask

        initial begin
                rst = 1'b1;
                run = 1'b0;
                extReq = '0;
                seed = 20;
                resetDut();
                testExtPort();
                testAlu();
                testLoadStore();
                testBranches();
                testJumps();
                $display("PASS: all tests");
                $finish;
        end

endmodule

/* source/multiCycleCore.sv */
module multiCycleCore (
        input logic clk,
        input logic rst,
        input logic run,
        input cpuPkg::memReq_t extReq,
        output logic extReady,
        output logic [31:0] extRdata,
        output logic halted
);
        import cpuPkg::*;

        ctrlSig_t ctrl;
        instr_t instr;
        memReq_t coreReq;
        logic zero, neg, coreSel, memReady, coreReady;
        logic running;
        logic [XLen-1:0] memRdata;

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        running <= 1'b0;
                else if (run)
                        running <= 1'b1;
        end

        // the core owns memory from run until halt.
        assign coreSel = running && !halted;
        assign coreReady = memReady && coreSel;
        assign extReady = memReady && !coreSel;
        assign extRdata = memRdata;

        mainController controller (
                .clk(clk), .rst(rst), .run(run), .instr(instr), .zero(zero), .neg(neg),
                .memReady(coreReady), .ctrl(ctrl), .halted(halted)
        );

        dataPath path (
                .clk(clk), .rst(rst), .ctrl(ctrl), .memRdata(memRdata), .memReady(coreReady),
                .instr(instr), .zero(zero), .neg(neg), .memReq(coreReq)
        );

        unifiedMemory memory (
                .clk(clk), .rst(rst), .coreReq(coreReq), .extReq(extReq), .coreSel(coreSel),
                .ready(memReady), .rdata(memRdata)
        );

endmodule

/* source/dataPath.sv */
module dataPath (
        input logic clk,
        input logic rst,
        input cpuPkg::ctrlSig_t ctrl,
        input logic [31:0] memRdata,
        input logic memReady,
        output cpuPkg::instr_t instr,
        output logic zero,
        output logic neg,
        output cpuPkg::memReq_t memReq
);
        import cpuPkg::*;

        logic [XLen-1:0] pc, oldPc, mdr, aluOut, adr;
        logic [XLen-1:0] rd1, rd2, imm, srcA, srcB, aluY, result;
        aluOp_t aluFn;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        pc <= '0;
                        oldPc <= '0;
                        instr <= '0;
                end else begin
                        if (ctrl.pcWrite)
                                pc <= result;
                        if (ctrl.irWrite && memReady) begin
                                instr <= memRdata;
                                oldPc <= pc;
                        end
                end
        end

        // aluOut holds still during a memory access.
        always_ff @(posedge clk) begin
                if (memReady)
                        mdr <= memRdata;
                if (!ctrl.memReqValid)
                        aluOut <= aluY;
        end

        always_comb begin
                case (ctrl.immSrc)
                        3'b000: imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                        3'b001: imm = {{20{instr.r.func7[6]}}, instr.r.func7, instr.r.rd};
                        3'b010: imm = {{19{instr.r.func7[6]}}, instr.r.func7[6], instr.r.rd[0],
                                       instr.r.func7[5:0], instr.r.rd[4:1], 1'b0};
                        3'b011: imm = {instr.r.func7, instr.r.rs2, instr.r.rs1, instr.r.func3, 12'b0};
                        default: imm = {{11{instr.r.func7[6]}}, instr.r.func7[6], instr.r.rs1,
                                        instr.r.func3, instr.r.rs2[0], instr.r.func7[5:0],
                                        instr.r.rs2[4:1], 1'b0};
                endcase
        end

        // 10 is register format, 11 immediate format without func7.
        always_comb begin
                case (ctrl.aluOp)
                        2'b00: aluFn = aluAdd;
                        2'b01: aluFn = aluSub;
                        default: begin
                                case (instr.r.func3)
                                        F3Add: aluFn = (ctrl.aluOp == 2'b10 && instr.r.func7[5]) ?
                                                       aluSub : aluAdd;
                                        F3Slt: aluFn = aluSlt;
                                        F3Or: aluFn = aluOr;
                                        F3And: aluFn = aluAnd;
                                        default: aluFn = aluAdd;
                                endcase
                        end
                endcase
        end

        assign srcA = ctrl.aluSrcA == 2'b00 ? pc :
                      ctrl.aluSrcA == 2'b01 ? oldPc :
                      ctrl.aluSrcA == 2'b10 ? rd1 : '0;
        assign srcB = ctrl.aluSrcB == 2'b00 ? rd2 :
                      ctrl.aluSrcB == 2'b01 ? imm : XLen'(4);

        // 11 returns the pc, which already points past the jump.
        assign result = ctrl.resultSrc == 2'b00 ? aluOut :
                        ctrl.resultSrc == 2'b01 ? mdr :
                        ctrl.resultSrc == 2'b10 ? aluY : pc;

        registerFile regFile (
                .clk(clk),
                .rst(rst),
                .ra1(instr.r.rs1),
                .ra2(instr.r.rs2),
                .wa(instr.r.rd),
                .we(ctrl.regWrite),
                .wd(result),
                .rd1(rd1),
                .rd2(rd2)
        );

        alu mainAlu (
                .a(srcA),
                .b(srcB),
                .op(aluFn),
                .y(aluY),
                .zero(zero),
                .neg(neg)
        );

        assign adr = ctrl.adrSrc ? aluOut : pc;
        assign memReq.valid = ctrl.memReqValid;
        assign memReq.write = ctrl.memWrite;
        assign memReq.addr = adr[MemAddrBits+1:2];
        assign memReq.wdata = rd2;

endmodule

/* source/mainController.sv */
module mainController (
        input logic clk,
        input logic rst,
        input logic run,
        input cpuPkg::instr_t instr,
        input logic zero,
        input logic neg,
        input logic memReady,
        output cpuPkg::ctrlSig_t ctrl,
        output logic halted
);
        import cpuPkg::*;

        ctrlState_t state;
        ctrlState_t next;
        logic take;
        logic isJalr;

        assign isJalr = instr.r.op == OpIType && instr.r.func3 == F3Jalr;

        always_ff @(posedge clk or posedge rst) begin
                if (rst)
                        state <= sIdle;
                else
                        state <= next;
        end

        always_comb begin
                next = state;
                case (state)
                        sIdle: if (run) next = sFetch;
                        sFetch: next = sFetchWait;
                        sFetchWait: if (memReady) next = sDecode;
                        sDecode: begin
                                case (instr.r.op)
                                        OpRType: next = sExReg;
                                        OpIType: next = isJalr ? sExJalr : sExImm;
                                        OpSType: next = sExStore;
                                        OpBType: next = sExBranch;
                                        OpUType: next = sExLui;
                                        OpJType: next = sExJal;
                                        OpHalt: next = sHalted;
                                        default: next = sFetch;
                                endcase
                        end
                        sExImm: next = (instr.r.func3 == F3Lw) ? sMemLoad : sWbAlu;
                        sExReg: next = sWbAlu;
                        sExStore: next = sMemStore;
                        sMemLoad: if (memReady) next = sWbLoad;
                        sMemStore: if (memReady) next = sFetch;
                        sHalted: next = sHalted;
                        default: next = sFetch;
                endcase
        end

        always_comb begin
                case (instr.r.func3)
                        F3Beq: take = zero;
                        F3Bne: take = !zero;
                        F3Blt: take = neg;
                        default: take = 1'b0;
                endcase
        end

        // mux codes as decoded in dataPath.
        always_comb begin
                ctrl = '0;
                case (state)
                        sFetch: ctrl.memReqValid = 1'b1;
                        sFetchWait: begin
                                // pc + 4 lands together with the instruction.
                                ctrl.memReqValid = 1'b1;
                                ctrl.irWrite = 1'b1;
                                ctrl.pcWrite = memReady;
                                ctrl.aluSrcB = 2'b10;
                                ctrl.resultSrc = 2'b10;
                        end
                        sDecode: begin
                                // jump target into aluOut, link into rd.
                                ctrl.aluSrcB = 2'b01;
                                if (instr.r.op == OpJType) begin
                                        ctrl.aluSrcA = 2'b01;
                                        ctrl.immSrc = 3'b100;
                                        ctrl.regWrite = 1'b1;
                                        ctrl.resultSrc = 2'b11;
                                end else if (isJalr) begin
                                        ctrl.aluSrcA = 2'b10;
                                        ctrl.immSrc = 3'b000;
                                        ctrl.regWrite = 1'b1;
                                        ctrl.resultSrc = 2'b11;
                                end else begin
                                        ctrl.aluSrcA = 2'b01;
                                        ctrl.immSrc = 3'b010;
                                end
                        end
                        sExImm: begin
                                ctrl.aluSrcA = 2'b10;
                                ctrl.aluSrcB = 2'b01;
                                ctrl.aluOp = (instr.r.func3 == F3Lw) ? 2'b00 : 2'b11;
                        end
                        sExReg: begin
                                ctrl.aluSrcA = 2'b10;
                                ctrl.aluOp = 2'b10;
                        end
                        sExBranch: begin
                                ctrl.aluSrcA = 2'b10;
                                ctrl.aluOp = 2'b01;
                                ctrl.pcWrite = take;
                        end
                        sExJal, sExJalr: ctrl.pcWrite = 1'b1;
                        sExStore: begin
                                ctrl.aluSrcA = 2'b10;
                                ctrl.aluSrcB = 2'b01;
                                ctrl.immSrc = 3'b001;
                        end
                        sExLui: begin
                                ctrl.aluSrcA = 2'b11;
                                ctrl.aluSrcB = 2'b01;
                                ctrl.immSrc = 3'b011;
                                ctrl.resultSrc = 2'b10;
                                ctrl.regWrite = 1'b1;
                        end
                        sMemLoad: begin
                                ctrl.memReqValid = 1'b1;
                                ctrl.adrSrc = 1'b1;
                        end
                        sMemStore: begin
                                ctrl.memReqValid = 1'b1;
                                ctrl.memWrite = 1'b1;
                                ctrl.adrSrc = 1'b1;
                        end
                        sWbLoad: begin
                                ctrl.resultSrc = 2'b01;
                                ctrl.regWrite = 1'b1;
                        end
                        sWbAlu: ctrl.regWrite = 1'b1;
                        default: ctrl = '0;
                endcase
        end

        assign halted = state == sHalted;

        assert property (@(posedge clk) disable iff (rst) ctrl.memWrite |-> ctrl.memReqValid);
        assert property (@(posedge clk) disable iff (rst) state <= sHalted);

endmodule

/* source/alu.sv */
module alu (
        input logic [31:0] a,
        input logic [31:0] b,
        input cpuPkg::aluOp_t op,
        output logic [31:0] y,
        output logic zero,
        output logic neg
);
        import cpuPkg::*;

        logic [31:0] diff;

        assign diff = a - b;

        always_comb begin
                case (op)
                        aluAdd: y = a + b;
                        aluSub: y = diff;
                        aluAnd: y = a & b;
                        aluOr: y = a | b;
                        aluSlt: y = {31'b0, $signed(a) < $signed(b)};
                        default: y = '0;
                endcase
        end

        assign zero = y == '0;

        // sign of a - b, used by blt.
        assign neg = diff[31];

endmodule

/* source/registerFile.sv */
module registerFile (
        input logic clk,
        input logic rst,
        input logic [4:0] ra1,
        input logic [4:0] ra2,
        input logic [4:0] wa,
        input logic we,
        input logic [31:0] wd,
        output logic [31:0] rd1,
        output logic [31:0] rd2
);
        logic [31:0] regs [32];

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++)
                                regs[i] <= '0;
                end else if (we && wa != 5'd0) begin
                        regs[wa] <= wd;
                end
        end

        // x0 is never written.
        assign rd1 = regs[ra1];
        assign rd2 = regs[ra2];

endmodule

/* source/unifiedMemory.sv */
module unifiedMemory (
        input logic clk,
        input logic rst,
        input cpuPkg::memReq_t coreReq,
        input cpuPkg::memReq_t extReq,
        input logic coreSel,
        output logic ready,
        output logic [31:0] rdata
);
        import cpuPkg::*;

        logic [XLen-1:0] mem [MemWords];
        memReq_t sel;
        logic timerStart;
        logic timerBusy;
        logic timerDone;

        assign sel = coreSel ? coreReq : extReq;

        // a fresh request starts the wait.
        assign timerStart = sel.valid && !timerBusy;

        accessTimer timer (
                .clk(clk),
                .rst(rst),
                .start(timerStart),
                .busy(timerBusy),
                .done(timerDone)
        );

        assign ready = timerDone;
        assign rdata = mem[sel.addr];

        always_ff @(posedge clk) begin
                if (timerDone && sel.write)
                        mem[sel.addr] <= sel.wdata;
        end

        assert property (@(posedge clk) disable iff (rst) timerBusy |-> $stable(sel));

endmodule

/* source/accessTimer.sv */
module accessTimer (
        input logic clk,
        input logic rst,
        input logic start,
        output logic busy,
        output logic done
);
        import cpuPkg::*;

        logic [$clog2(MemLatency)-1:0] count;

        always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                        busy <= 1'b0;
                        count <= '0;
                end else if (start && !busy) begin
                        busy <= 1'b1;
                        count <= MemLatency[$clog2(MemLatency)-1:0] - 1'b1;
                end else if (busy) begin
                        if (count == '0)
                                busy <= 1'b0;
                        else
                                count <= count - 1'b1;
                end
        end

        assign done = busy && count == '0;

        assert property (@(posedge clk) disable iff (rst) busy |-> !start);

endmodule

/* source/cpuPkg.sv */
package cpuPkg;

        localparam int XLen = 32;
        localparam int MemWords = 256;
        localparam int MemAddrBits = 8;
        localparam int MemLatency = 3;

        // opcode classes.
        localparam logic [6:0] OpRType = 7'd0;
        localparam logic [6:0] OpIType = 7'd1;
        localparam logic [6:0] OpSType = 7'd2;
        localparam logic [6:0] OpBType = 7'd3;
        localparam logic [6:0] OpUType = 7'd4;
        localparam logic [6:0] OpJType = 7'd5;
        localparam logic [6:0] OpHalt = 7'd127;

        localparam logic [2:0] F3Lw = 3'd6;
        localparam logic [2:0] F3Jalr = 3'd7;
        localparam logic [2:0] F3Add = 3'd0;
        localparam logic [2:0] F3Slt = 3'd2;
        localparam logic [2:0] F3Or = 3'd6;
        localparam logic [2:0] F3And = 3'd7;
        localparam logic [2:0] F3Beq = 3'd0;
        localparam logic [2:0] F3Bne = 3'd1;
        localparam logic [2:0] F3Blt = 3'd4;

        typedef enum logic [4:0] {
                sIdle, sFetch, sFetchWait, sDecode,
                sExImm, sExReg, sExBranch, sExJal, sExJalr, sExStore, sExLui,
                sMemLoad, sMemStore, sWbLoad, sWbAlu, sHalted
        } ctrlState_t;

        typedef struct packed {
                logic [6:0] func7;
                logic [4:0] rs2;
                logic [4:0] rs1;
                logic [2:0] func3;
                logic [4:0] rd;
                logic [6:0] op;
        } rView_t;

        typedef struct packed {
                logic [11:0] imm12;
                logic [4:0] rs1;
                logic [2:0] func3;
                logic [4:0] rd;
                logic [6:0] op;
        } iView_t;

        typedef union packed {
                rView_t r;
                iView_t i;
        } instr_t;

        typedef struct packed {
                logic pcWrite;
                logic irWrite;
                logic adrSrc;
                logic regWrite;
                logic memReqValid;
                logic memWrite;
                logic [1:0] aluSrcA;
                logic [1:0] aluSrcB;
                logic [1:0] aluOp;
                logic [1:0] resultSrc;
                logic [2:0] immSrc;
        } ctrlSig_t;

        typedef struct packed {
                logic valid;
                logic write;
                logic [MemAddrBits-1:0] addr;
                logic [XLen-1:0] wdata;
        } memReq_t;

        typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;

endpackage
